// File: source/trace_pkg.sv
/*
 * Trace pipeline package
 * Sizes, widths and operation encodings shared by the filter-reduce unit
 */

package trace_pkg;

  // ----------------------------------------------------------
  // Vector geometry
  // ----------------------------------------------------------

  // Lanes per vector and bits per lane
  localparam int N_LANES    = 8;
  localparam int DATA_WIDTH = 32;

  // Lane index width, also the depth of the reduce tree
  localparam int LANE_W = 3;

  // ----------------------------------------------------------
  // Chains and operand memory
  // ----------------------------------------------------------

  localparam int MAX_CHAINS = 4;
  localparam int CHAIN_W    = 2;

  localparam int OPERAND_DEPTH  = 16;
  localparam int OPERAND_ADDR_W = 4;

  // Intake to output, filter takes 2 and reduce takes 1
  localparam int PIPE_LATENCY = 3;

  // ----------------------------------------------------------
  // Operation encodings
  // ----------------------------------------------------------

  typedef enum logic [1:0] {
    FILTER_PASS = 2'd0,
    FILTER_ADD  = 2'd1,
    FILTER_SUB  = 2'd2,
    FILTER_MAX  = 2'd3
  } filter_op_e;

  // Encoding 3 is unused
  typedef enum logic [1:0] {
    REDUCE_PASS = 2'd0,
    REDUCE_SUM  = 2'd1,
    REDUCE_MAX  = 2'd2
  } reduce_op_e;

  // What a configuration write changes
  typedef enum logic [1:0] {
    CFG_FILTER_OP   = 2'd0,
    CFG_FILTER_ADDR = 2'd1,
    CFG_REDUCE_OP   = 2'd2,
    CFG_OPERAND     = 2'd3
  } cfg_target_e;

endpackage

// File: source/chain_config.sv
/*
 * Chain configuration tables
 * Per-chain filter op, operand address and reduce op, written through the
 * configuration port and looked up combinationally by chain id
 */

`timescale 1ns/1ps

module chain_config import trace_pkg::*; (
  input  logic                      clk,
  input  logic                      reset,
  input  logic                      cfg_write,
  input  cfg_target_e               cfg_target,
  input  logic [CHAIN_W-1:0]        cfg_chain,
  input  logic [DATA_WIDTH-1:0]     cfg_data,
  input  logic [CHAIN_W-1:0]        chain_id,
  output filter_op_e                filter_op,
  output logic [OPERAND_ADDR_W-1:0] operand_addr,
  output reduce_op_e                reduce_op
);

  // Firmware tables, one entry per chain
  filter_op_e                filter_tbl [MAX_CHAINS];
  logic [OPERAND_ADDR_W-1:0] addr_tbl   [MAX_CHAINS];
  reduce_op_e                reduce_tbl [MAX_CHAINS];

  // ----------------------------------------------------------
  // Table update
  // ----------------------------------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int c = 0; c < MAX_CHAINS; c++) begin
        filter_tbl[c] <= FILTER_PASS;
        addr_tbl[c]   <= '0;
        reduce_tbl[c] <= REDUCE_PASS;
      end
    end else if (cfg_write) begin
      case (cfg_target)
        CFG_FILTER_OP: begin
          filter_tbl[cfg_chain] <= filter_op_e'(cfg_data[1:0]);
        end
        CFG_FILTER_ADDR: begin
          addr_tbl[cfg_chain] <= cfg_data[OPERAND_ADDR_W-1:0];
        end
        CFG_REDUCE_OP: begin
          reduce_tbl[cfg_chain] <= reduce_op_e'(cfg_data[1:0]);
        end
        // Operand writes go to the memory, not to these tables
        default: begin
        end
      endcase
    end
  end

  // Lookup for the vector being presented this cycle
  assign filter_op    = filter_tbl[chain_id];
  assign operand_addr = addr_tbl[chain_id];
  assign reduce_op    = reduce_tbl[chain_id];

  // Op table writes must carry a value inside the enum
  op_write_legal: assert property (
    @(posedge clk) disable iff (reset)
    (cfg_write && (cfg_target == CFG_FILTER_OP || cfg_target == CFG_REDUCE_OP))
      |-> (cfg_data <= ((cfg_target == CFG_FILTER_OP) ? DATA_WIDTH'(FILTER_MAX)
                                                      : DATA_WIDTH'(REDUCE_MAX)))
  );

endmodule

// File: source/operand_ram.sv
/*
 * Operand memory
 * Lane-writable vector memory with one registered read port
 */

`timescale 1ns/1ps

module operand_ram import trace_pkg::*; (
  input  logic                                clk,
  input  logic                                write_enable,
  input  logic [OPERAND_ADDR_W-1:0]           write_addr,
  input  logic [LANE_W-1:0]                   write_lane,
  input  logic [DATA_WIDTH-1:0]               write_data,
  input  logic [OPERAND_ADDR_W-1:0]           read_addr,
  output logic [N_LANES-1:0][DATA_WIDTH-1:0]  read_word
);

  // One full vector per word
  logic [N_LANES-1:0][DATA_WIDTH-1:0] mem [OPERAND_DEPTH];

  // ----------------------------------------------------------
  // Write side
  // ----------------------------------------------------------

  // Only the addressed lane changes
  always_ff @(posedge clk) begin
    if (write_enable) begin
      mem[write_addr][write_lane] <= write_data;
    end
  end

  // ----------------------------------------------------------
  // Read side
  // ----------------------------------------------------------

  // Registered read, word is valid the cycle after the address
  always_ff @(posedge clk) begin
    read_word <= mem[read_addr];
  end

endmodule

// File: source/filter_stage.sv
/*
 * Filter stage
 * Fetches the chain's operand word and combines it lane by lane with the
 * incoming vector, two cycles from intake to output
 */

`timescale 1ns/1ps

module filter_stage import trace_pkg::*; (
  input  logic                               clk,
  input  logic                               reset,
  input  logic                               tracing,
  input  logic                               valid_in,
  input  logic                               eof_in,
  input  logic [CHAIN_W-1:0]                 chain_id_in,
  input  logic [N_LANES-1:0][DATA_WIDTH-1:0] vector_in,
  input  filter_op_e                         filter_op,
  input  logic [OPERAND_ADDR_W-1:0]          operand_addr,
  input  reduce_op_e                         reduce_op,
  input  logic [N_LANES-1:0][DATA_WIDTH-1:0] operand_word,
  output logic [OPERAND_ADDR_W-1:0]          operand_read_addr,
  output logic                               filt_valid,
  output logic                               filt_eof,
  output logic [CHAIN_W-1:0]                 filt_chain,
  output logic [N_LANES-1:0][DATA_WIDTH-1:0] filt_vector,
  output reduce_op_e                         filt_reduce_op
);

  logic                               take;

  // First cycle registers, aligned with the memory read
  logic                               s1_valid;
  logic                               s1_eof;
  logic [CHAIN_W-1:0]                 s1_chain;
  logic [N_LANES-1:0][DATA_WIDTH-1:0] s1_vector;
  filter_op_e                         s1_filter_op;
  reduce_op_e                         s1_reduce_op;

  logic [N_LANES-1:0][DATA_WIDTH-1:0] filter_result;

  // Vectors arriving while tracing is off are dropped
  assign take = valid_in && tracing;

  // The memory samples the chain's address on the intake edge
  assign operand_read_addr = operand_addr;

  // ----------------------------------------------------------
  // Cycle 1 ... hold vector and ops while the operand is read
  // ----------------------------------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      s1_valid <= 1'b0;
      s1_eof   <= 1'b0;
    end else begin
      s1_valid <= take;
      s1_eof   <= take && eof_in;
    end
  end

  always_ff @(posedge clk) begin
    s1_chain     <= chain_id_in;
    s1_vector    <= vector_in;
    s1_filter_op <= filter_op;
    s1_reduce_op <= reduce_op;
  end

  // ----------------------------------------------------------
  // Cycle 2 ... lane-wise filter against the operand word
  // ----------------------------------------------------------

  always_comb begin
    for (int l = 0; l < N_LANES; l++) begin
      case (s1_filter_op)
        FILTER_ADD: filter_result[l] = s1_vector[l] + operand_word[l];
        FILTER_SUB: filter_result[l] = s1_vector[l] - operand_word[l];
        FILTER_MAX: begin
          filter_result[l] = (s1_vector[l] > operand_word[l]) ? s1_vector[l]
                                                              : operand_word[l];
        end
        default:    filter_result[l] = s1_vector[l];
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      filt_valid <= 1'b0;
      filt_eof   <= 1'b0;
    end else begin
      filt_valid <= s1_valid;
      filt_eof   <= s1_eof;
    end
  end

  always_ff @(posedge clk) begin
    filt_chain     <= s1_chain;
    filt_vector    <= filter_result;
    filt_reduce_op <= s1_reduce_op;
  end

  // Downstream qualifies everything on this strobe
  filt_valid_known: assert property (
    @(posedge clk) disable iff (reset) !$isunknown(filt_valid)
  );

endmodule

// File: source/reduce_stage.sv
/*
 * Reduce stage
 * Folds the filtered vector into lane 0 by sum or unsigned max through a
 * pairwise lane tree, or passes it, with one registered cycle
 */

`timescale 1ns/1ps

module reduce_stage import trace_pkg::*; (
  input  logic                               clk,
  input  logic                               reset,
  input  logic                               filt_valid,
  input  logic                               filt_eof,
  input  logic [CHAIN_W-1:0]                 filt_chain,
  input  logic [N_LANES-1:0][DATA_WIDTH-1:0] filt_vector,
  input  reduce_op_e                         filt_reduce_op,
  output logic                               valid_out,
  output logic                               eof_out,
  output logic [CHAIN_W-1:0]                 chain_id_out,
  output logic [N_LANES-1:0][DATA_WIDTH-1:0] vector_out
);

  // Tree nodes, each level overwrites the lower half of the previous
  logic [DATA_WIDTH-1:0] sum_node [N_LANES];
  logic [DATA_WIDTH-1:0] max_node [N_LANES];

  logic [N_LANES-1:0][DATA_WIDTH-1:0] reduce_result;

  // ----------------------------------------------------------
  // Pairwise lane tree, LANE_W levels deep
  // ----------------------------------------------------------

  always_comb begin
    for (int l = 0; l < N_LANES; l++) begin
      sum_node[l] = filt_vector[l];
      max_node[l] = filt_vector[l];
    end
    // Node i reads 2i and 2i+1, which are not yet written at this level
    for (int lvl = 0; lvl < LANE_W; lvl++) begin
      for (int i = 0; i < (N_LANES >> (lvl + 1)); i++) begin
        sum_node[i] = sum_node[2*i] + sum_node[2*i+1];
        max_node[i] = (max_node[2*i] > max_node[2*i+1]) ? max_node[2*i]
                                                        : max_node[2*i+1];
      end
    end
  end

  // Folding ops leave the result in lane 0 only
  always_comb begin
    reduce_result = '0;
    case (filt_reduce_op)
      REDUCE_SUM: reduce_result[0] = sum_node[0];
      REDUCE_MAX: reduce_result[0] = max_node[0];
      default:    reduce_result    = filt_vector;
    endcase
  end

  // ----------------------------------------------------------
  // Output registers
  // ----------------------------------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      valid_out <= 1'b0;
      eof_out   <= 1'b0;
    end else begin
      valid_out <= filt_valid;
      eof_out   <= filt_eof;
    end
  end

  always_ff @(posedge clk) begin
    chain_id_out <= filt_chain;
    vector_out   <= reduce_result;
  end

  // A bad table entry would otherwise silently pass the vector
  reduce_op_legal: assert property (
    @(posedge clk) disable iff (reset)
    filt_valid |-> (filt_reduce_op inside {REDUCE_PASS, REDUCE_SUM, REDUCE_MAX})
  );

endmodule

// File: source/filter_reduce_top.sv
/*
 * Filter-reduce unit
 * Per-chain configuration, operand memory, filter stage and reduce stage
 */

`timescale 1ns/1ps

module filter_reduce_top import trace_pkg::*; (
  input  logic                               clk,
  input  logic                               reset,
  input  logic                               tracing,
  // Configuration port
  input  logic                               cfg_write,
  input  cfg_target_e                        cfg_target,
  input  logic [CHAIN_W-1:0]                 cfg_chain,
  input  logic [OPERAND_ADDR_W-1:0]          cfg_addr,
  input  logic [LANE_W-1:0]                  cfg_lane,
  input  logic [DATA_WIDTH-1:0]              cfg_data,
  // Data port
  input  logic                               valid_in,
  input  logic                               eof_in,
  input  logic [CHAIN_W-1:0]                 chain_id_in,
  input  logic [N_LANES-1:0][DATA_WIDTH-1:0] vector_in,
  output logic                               valid_out,
  output logic                               eof_out,
  output logic [CHAIN_W-1:0]                 chain_id_out,
  output logic [N_LANES-1:0][DATA_WIDTH-1:0] vector_out
);

  // Lookup results for the incoming chain
  filter_op_e                         filter_op;
  logic [OPERAND_ADDR_W-1:0]          operand_addr;
  reduce_op_e                         reduce_op;

  // Operand memory read path
  logic [OPERAND_ADDR_W-1:0]          operand_read_addr;
  logic [N_LANES-1:0][DATA_WIDTH-1:0] operand_word;

  // Filter to reduce
  logic                               filt_valid;
  logic                               filt_eof;
  logic [CHAIN_W-1:0]                 filt_chain;
  logic [N_LANES-1:0][DATA_WIDTH-1:0] filt_vector;
  reduce_op_e                         filt_reduce_op;

  chain_config u_chain_config (
    .clk          (clk),
    .reset        (reset),
    .cfg_write    (cfg_write),
    .cfg_target   (cfg_target),
    .cfg_chain    (cfg_chain),
    .cfg_data     (cfg_data),
    .chain_id     (chain_id_in),
    .filter_op    (filter_op),
    .operand_addr (operand_addr),
    .reduce_op    (reduce_op)
  );

  operand_ram u_operand_ram (
    .clk          (clk),
    .write_enable (cfg_write && (cfg_target == CFG_OPERAND)),
    .write_addr   (cfg_addr),
    .write_lane   (cfg_lane),
    .write_data   (cfg_data),
    .read_addr    (operand_read_addr),
    .read_word    (operand_word)
  );

  filter_stage u_filter_stage (
    .clk               (clk),
    .reset             (reset),
    .tracing           (tracing),
    .valid_in          (valid_in),
    .eof_in            (eof_in),
    .chain_id_in       (chain_id_in),
    .vector_in         (vector_in),
    .filter_op         (filter_op),
    .operand_addr      (operand_addr),
    .reduce_op         (reduce_op),
    .operand_word      (operand_word),
    .operand_read_addr (operand_read_addr),
    .filt_valid        (filt_valid),
    .filt_eof          (filt_eof),
    .filt_chain        (filt_chain),
    .filt_vector       (filt_vector),
    .filt_reduce_op    (filt_reduce_op)
  );

  reduce_stage u_reduce_stage (
    .clk            (clk),
    .reset          (reset),
    .filt_valid     (filt_valid),
    .filt_eof       (filt_eof),
    .filt_chain     (filt_chain),
    .filt_vector    (filt_vector),
    .filt_reduce_op (filt_reduce_op),
    .valid_out      (valid_out),
    .eof_out        (eof_out),
    .chain_id_out   (chain_id_out),
    .vector_out     (vector_out)
  );

endmodule

// File: test/tb_filter_reduce.sv
/*
 * Filter-reduce testbench
 * Drives configuration and vectors and checks every output against a reference model
 */

`timescale 1ns/1ps

module tb_filter_reduce import trace_pkg::*; ();

  typedef logic [N_LANES-1:0][DATA_WIDTH-1:0] vector_t;

  localparam int DRAIN_LIMIT = 50;

  logic                      clk;
  logic                      reset;
  logic                      tracing;
  logic                      cfg_write;
  cfg_target_e               cfg_target;
  logic [CHAIN_W-1:0]        cfg_chain;
  logic [OPERAND_ADDR_W-1:0] cfg_addr;
  logic [LANE_W-1:0]         cfg_lane;
  logic [DATA_WIDTH-1:0]     cfg_data;
  logic                      valid_in;
  logic                      eof_in;
  logic [CHAIN_W-1:0]        chain_id_in;
  vector_t                   vector_in;
  logic                      valid_out;
  logic                      eof_out;
  logic [CHAIN_W-1:0]        chain_id_out;
  vector_t                   vector_out;

  // Shadow copies of the firmware tables and operand memory
  filter_op_e                sh_filter [MAX_CHAINS];
  logic [OPERAND_ADDR_W-1:0] sh_addr   [MAX_CHAINS];
  reduce_op_e                sh_reduce [MAX_CHAINS];
  logic [DATA_WIDTH-1:0]     sh_mem    [OPERAND_DEPTH][N_LANES];

  // Expected outputs in intake order
  vector_t            exp_vec   [$];
  logic               exp_eof   [$];
  logic [CHAIN_W-1:0] exp_chain [$];
  int                 exp_due   [$];

  int   cycle;
  logic out_of_reset;
  int   seed;

  filter_reduce_top u_filter_reduce_top (.*);

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // Cycle count and reset status for the falling-edge processes
  always @(posedge clk) begin
    cycle <= cycle + 1;
    if (!reset) out_of_reset <= 1'b1;
  end

  // ----------------------------------------------------------
  // Reporting
  // ----------------------------------------------------------

  task automatic report_failure();
    $display("SOME TESTS FAILED");
    $fatal(1, "Simulation stopped at the first failure");
  endtask

  task automatic check_value(input string what, input logic [DATA_WIDTH-1:0] got,
                             input logic [DATA_WIDTH-1:0] expected);
    if (got !== expected) begin
      $display("ERROR at %0t: %s is %h, expected %h", $time, what, got, expected);
      report_failure();
    end
  endtask

  // ----------------------------------------------------------
  // Reference model
  // ----------------------------------------------------------

  function automatic vector_t expected_vector(input logic [CHAIN_W-1:0] chain,
                                              input vector_t vec);
    vector_t               filt;
    vector_t               res;
    logic [DATA_WIDTH-1:0] opnd;
    logic [DATA_WIDTH-1:0] acc_sum;
    logic [DATA_WIDTH-1:0] acc_max;
    for (int l = 0; l < N_LANES; l++) begin
      opnd = sh_mem[sh_addr[chain]][l];
      case (sh_filter[chain])
        FILTER_ADD: filt[l] = vec[l] + opnd;
        FILTER_SUB: filt[l] = vec[l] - opnd;
        FILTER_MAX: filt[l] = (vec[l] > opnd) ? vec[l] : opnd;
        default:    filt[l] = vec[l];
      endcase
    end
    acc_sum = '0;
    acc_max = '0;
    for (int l = 0; l < N_LANES; l++) begin
      acc_sum = acc_sum + filt[l];
      if (filt[l] > acc_max) acc_max = filt[l];
    end
    res = '0;
    case (sh_reduce[chain])
      REDUCE_SUM: res[0] = acc_sum;
      REDUCE_MAX: res[0] = acc_max;
      default:    res = filt;
    endcase
    return res;
  endfunction

  // Outputs are sampled on the falling edge where they are stable
  always @(negedge clk) begin : compare_outputs
    logic    due_now;
    vector_t want;
    if (out_of_reset) begin
      due_now = 1'b0;
      if (exp_due.size() != 0) due_now = (exp_due[0] == cycle);
      check_value("valid_out", DATA_WIDTH'(valid_out), DATA_WIDTH'(due_now));
      if (due_now) begin
        want = exp_vec.pop_front();
        check_value("eof_out", DATA_WIDTH'(eof_out), DATA_WIDTH'(exp_eof.pop_front()));
        check_value("chain_id_out", DATA_WIDTH'(chain_id_out),
                    DATA_WIDTH'(exp_chain.pop_front()));
        for (int l = 0; l < N_LANES; l++) begin
          check_value($sformatf("vector_out lane %0d", l), vector_out[l], want[l]);
        end
        void'(exp_due.pop_front());
      end else begin
        check_value("idle eof_out", DATA_WIDTH'(eof_out), '0);
      end
    end
  end

  // ----------------------------------------------------------
  // Stimulus tasks enter and leave on a falling edge
  // ----------------------------------------------------------

  task automatic write_config(input cfg_target_e target, input logic [CHAIN_W-1:0] chain,
                              input logic [OPERAND_ADDR_W-1:0] addr,
                              input logic [LANE_W-1:0] lane,
                              input logic [DATA_WIDTH-1:0] data);
    cfg_write  = 1'b1;
    cfg_target = target;
    cfg_chain  = chain;
    cfg_addr   = addr;
    cfg_lane   = lane;
    cfg_data   = data;
    case (target)
      CFG_FILTER_OP:   sh_filter[chain] = filter_op_e'(data[1:0]);
      CFG_FILTER_ADDR: sh_addr[chain] = data[OPERAND_ADDR_W-1:0];
      CFG_REDUCE_OP:   sh_reduce[chain] = reduce_op_e'(data[1:0]);
      default:         sh_mem[addr][lane] = data;
    endcase
    @(negedge clk);
    cfg_write = 1'b0;
  endtask

  task automatic set_chain(input logic [CHAIN_W-1:0] chain, input filter_op_e fop,
                           input logic [OPERAND_ADDR_W-1:0] addr, input reduce_op_e rop);
    write_config(CFG_FILTER_OP, chain, '0, '0, DATA_WIDTH'(fop));
    write_config(CFG_FILTER_ADDR, chain, '0, '0, DATA_WIDTH'(addr));
    write_config(CFG_REDUCE_OP, chain, '0, '0, DATA_WIDTH'(rop));
  endtask

  // A taken vector is due PIPE_LATENCY cycles after this one
  task automatic send_vector(input logic [CHAIN_W-1:0] chain, input logic eof,
                             input vector_t vec);
    valid_in    = 1'b1;
    eof_in      = eof;
    chain_id_in = chain;
    vector_in   = vec;
    if (tracing) begin
      exp_vec.push_back(expected_vector(chain, vec));
      exp_eof.push_back(eof);
      exp_chain.push_back(chain);
      exp_due.push_back(cycle + PIPE_LATENCY);
    end
    @(negedge clk);
  endtask

  task automatic idle(input int cycles);
    valid_in = 1'b0;
    eof_in   = 1'b0;
    repeat (cycles) @(negedge clk);
  endtask

  task automatic drain();
    int waited;
    idle(0);
    waited = 0;
    while (exp_due.size() != 0) begin
      if (waited >= DRAIN_LIMIT) begin
        $display("Timeout: pipeline still owes %0d outputs", exp_due.size());
        report_failure();
      end
      @(negedge clk);
      waited++;
    end
    idle(2);
  endtask

  function automatic vector_t random_vector();
    vector_t v;
    for (int l = 0; l < N_LANES; l++) v[l] = $random(seed);
    return v;
  endfunction

  // ----------------------------------------------------------
  // Test sequence
  // ----------------------------------------------------------

  initial begin : main
    int      r;
    int      len;
    vector_t vec;
    seed = 32'hbe3a8262;
    cycle = 0;
    out_of_reset = 1'b0;
    reset = 1'b1;
    tracing = 1'b1;
    cfg_write = 1'b0;
    cfg_target = CFG_FILTER_OP;
    cfg_chain = '0;
    cfg_addr = '0;
    cfg_lane = '0;
    cfg_data = '0;
    valid_in = 1'b0;
    eof_in = 1'b0;
    chain_id_in = '0;
    vector_in = '0;
    for (int c = 0; c < MAX_CHAINS; c++) begin
      sh_filter[c] = FILTER_PASS;
      sh_addr[c]   = '0;
      sh_reduce[c] = REDUCE_PASS;
    end
    repeat (4) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;

    // Fill pattern mixes every address and lane bit
    for (int a = 0; a < OPERAND_DEPTH; a++) begin
      for (int l = 0; l < N_LANES; l++) begin
        write_config(CFG_OPERAND, '0, OPERAND_ADDR_W'(a), LANE_W'(l),
                     32'h9e37_79b9 * DATA_WIDTH'(a * N_LANES + l + 1));
      end
    end

    // Idle after reset and then default settings on every chain
    idle(10);
    for (int i = 0; i < 12; i++) send_vector(CHAIN_W'(i), (i % 3 == 2), random_vector());
    drain();

    // One filter op per chain with operands chosen to wrap
    for (int l = 0; l < N_LANES; l++) begin
      write_config(CFG_OPERAND, '0, 4'd5, LANE_W'(l), 32'hffff_fff0 + DATA_WIDTH'(l));
      write_config(CFG_OPERAND, '0, 4'd9, LANE_W'(l), 32'h8000_0000 + DATA_WIDTH'(l));
    end
    set_chain(2'd0, FILTER_PASS, 4'd3, REDUCE_PASS);
    set_chain(2'd1, FILTER_ADD, 4'd5, REDUCE_PASS);
    set_chain(2'd2, FILTER_SUB, 4'd9, REDUCE_PASS);
    set_chain(2'd3, FILTER_MAX, 4'd14, REDUCE_PASS);
    for (int i = 0; i < 16; i++) begin
      vec = random_vector();
      for (int l = 0; l < N_LANES; l++) begin
        if (i < 4) vec[l] = DATA_WIDTH'(l + 1);
        else if (i < 8) vec[l] = 32'hffff_ff00 + DATA_WIDTH'(l);
      end
      send_vector(CHAIN_W'(i), (i % 4 == 3), vec);
    end
    drain();

    // Folding reduce ops on top of the filters
    write_config(CFG_REDUCE_OP, 2'd0, '0, '0, DATA_WIDTH'(REDUCE_SUM));
    write_config(CFG_REDUCE_OP, 2'd1, '0, '0, DATA_WIDTH'(REDUCE_MAX));
    write_config(CFG_REDUCE_OP, 2'd2, '0, '0, DATA_WIDTH'(REDUCE_SUM));
    write_config(CFG_REDUCE_OP, 2'd3, '0, '0, DATA_WIDTH'(REDUCE_MAX));
    for (int i = 0; i < 12; i++) send_vector(CHAIN_W'(i), (i % 2 == 1), random_vector());
    drain();

    // Vectors dropped while tracing is low and intake resuming when it rises
    tracing = 1'b0;
    for (int i = 0; i < 4; i++) send_vector(CHAIN_W'(i), 1'b1, random_vector());
    tracing = 1'b1;
    for (int i = 0; i < 12; i++) begin
      tracing = (i < 4) || (i % 2 == 0);
      send_vector(CHAIN_W'(i), (i % 3 == 0), random_vector());
    end
    tracing = 1'b1;
    drain();

    // Random bursts with random configuration in between
    for (int b = 0; b < 20; b++) begin
      len = 1 + ($random(seed) & 3);
      for (int w = 0; w < len; w++) begin
        r = $random(seed);
        case (r[1:0])
          2'd0: write_config(CFG_FILTER_OP, r[3:2], '0, '0, DATA_WIDTH'(r[12:11]));
          2'd1: write_config(CFG_FILTER_ADDR, r[3:2], '0, '0, DATA_WIDTH'(r[16:13]));
          2'd2: write_config(CFG_REDUCE_OP, r[3:2], '0, '0,
                             (r[18:17] == 2'd3) ? '0 : DATA_WIDTH'(r[18:17]));
          default: write_config(CFG_OPERAND, '0, r[7:4], r[10:8], $random(seed));
        endcase
      end
      len = 1 + ($random(seed) & 7);
      for (int i = 0; i < len; i++) begin
        r = $random(seed);
        tracing = (r[2:0] != 3'd0);
        send_vector(r[4:3], r[5], random_vector());
      end
      tracing = 1'b1;
      drain();
    end

    idle(5);
    $display("ALL TESTS PASSED");
    $finish;
  end

endmodule

// File: project.f
source/trace_pkg.sv
source/chain_config.sv
source/operand_ram.sv
source/filter_stage.sv
source/reduce_stage.sv
source/filter_reduce_top.sv
test/tb_filter_reduce.sv

// File: Makefile
# Verilator build and run for the filter-reduce testbench
# Any variable below can be overridden on the command line

VERILATOR ?= verilator
TOP       ?= tb_filter_reduce
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

FAIL_TEXT := SOME TESTS FAILED
PASS_TEXT := ALL TESTS PASSED

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

# The log decides the result, the simulator exit code is not trusted
run: compile
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_TEXT)" $(LOG); then \
		echo "Simulation reported failure"; exit 1; \
	fi
	@if ! grep -q "$(PASS_TEXT)" $(LOG); then \
		echo "Simulation ended without a result"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
